// ==== src.f ====
+incdir+hw
hw/mxint_pkg.sv
hw/mx_split_buffer.sv
hw/fixed_dot_product.sv
hw/mx_result_join.sv
hw/mxint_dot_product.sv
dv/mxint_dot_product_assertions.sv
dv/mxint_dot_product_tb.sv

// ==== Bender.yml ====
package:
  name: mxint_dot_product

sources:
  - include_dirs:
      - hw
    files:
      - hw/mxint_pkg.sv
      - hw/mx_split_buffer.sv
      - hw/fixed_dot_product.sv
      - hw/mx_result_join.sv
      - hw/mxint_dot_product.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/mxint_dot_product_assertions.sv
      - dv/mxint_dot_product_tb.sv

// ==== dv/mxint_dot_product_tb.sv ====
`timescale 1ns/1ps
`include "mxint_macros.svh"

module mxint_dot_product_tb;
  import mxint_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 4;
  localparam int TOTAL_RESULTS = 300;
  localparam int WAIT_LIMIT    = 4000;
  localparam int HOLD_CYCLES   = 20;
  localparam int LATENCY       = 5;
  localparam int SEED          = 65104;

  localparam int READY_LOW    = 0;
  localparam int READY_HIGH   = 1;
  localparam int READY_RANDOM = 2;

  logic       clk;
  logic       rst_n        = 1'b0;
  mx_block_t  act          = '0;
  logic       act_valid    = 1'b0;
  logic       act_ready;
  mx_block_t  weight       = '0;
  logic       weight_valid = 1'b0;
  logic       weight_ready;
  mx_result_t result;
  logic       result_valid;
  logic       result_ready = 1'b0;

  int seed        = SEED;
  int act_seed    = SEED + 1; // each driver draws from its own sequence.
  int weight_seed = SEED + 2;
  int ready_seed  = SEED + 3;

  mx_block_t act_todo[$];
  mx_block_t weight_todo[$];
  mx_block_t act_q[$];
  mx_block_t weight_q[$];

  int    act_gap        = 0;
  int    weight_gap     = 0;
  int    act_gap_max    = 0;
  int    weight_gap_max = 0;
  int    ready_mode     = READY_HIGH;
  int    ready_burst    = 0;
  int    result_count   = 0;
  string test_name      = "reset";

  mxint_dot_product uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .act          (act),
    .act_valid    (act_valid),
    .act_ready    (act_ready),
    .weight       (weight),
    .weight_valid (weight_valid),
    .weight_ready (weight_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_value_error(input string what, input int expected, input int actual);
    $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, expected, actual);
    stop_on_failure();
  endtask

  task automatic report_failure(input string msg);
    $display("[%s] %s", test_name, msg);
    stop_on_failure();
  endtask

  // extreme values show up often so the sign and overflow corners get hit.
  function automatic int pick_value(input int width);
    int r;
    r = {$random(seed)} % 8;
    if (r == 0) begin
      return -(1 << (width - 1));
    end else if (r == 1) begin
      return (1 << (width - 1)) - 1;
    end
    return $random(seed);
  endfunction

  function automatic mx_block_t random_block();
    mx_block_t blk;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      blk.man[i] = man_t'(pick_value(`MX_MAN_W));
    end
    blk.exp = exp_t'(pick_value(`MX_EXP_W));
    return blk;
  endfunction

  function automatic acc_t expected_sum(input mx_block_t a, input mx_block_t w);
    int total;
    total = 0;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      total += int'(a.man[i]) * int'(w.man[i]);
    end
    return acc_t'(total);
  endfunction

  function automatic out_exp_t expected_exp(input mx_block_t a, input mx_block_t w);
    return out_exp_t'(int'(a.exp) + int'(w.exp));
  endfunction

  task automatic queue_blocks(input int n_act, input int n_weight);
    for (int i = 0; i < n_act; i++) begin
      act_todo.push_back(random_block());
    end
    for (int i = 0; i < n_weight; i++) begin
      weight_todo.push_back(random_block());
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (act_todo.size() != 0 || weight_todo.size() != 0 || act_valid || weight_valid ||
           act_gap != 0 || weight_gap != 0 || act_q.size() != 0 || weight_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_failure("timed out waiting for all blocks to come out as results");
      end
    end
  endtask

  task automatic wait_both_accepted();
    int waited;
    waited = 0;
    while (!(act_valid && act_ready && weight_valid && weight_ready)) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_failure("timed out waiting for both blocks to be accepted together");
      end
    end
  endtask

  task automatic wait_result_valid();
    int waited;
    waited = 0;
    while (!result_valid) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_failure("timed out waiting for result_valid");
      end
    end
  endtask

  // a driver holds its block until the handshake, then waits a random gap.
  always @(posedge clk) begin
    if (!rst_n) begin
      act_valid <= 1'b0;
      act_gap = 0;
    end else if (!act_valid || act_ready) begin
      if (act_gap > 0) begin
        act_valid <= 1'b0;
        act_gap--;
      end else if (act_todo.size() > 0) begin
        act       <= act_todo.pop_front();
        act_valid <= 1'b1;
        act_gap = {$random(act_seed)} % (act_gap_max + 1);
      end else begin
        act_valid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      weight_valid <= 1'b0;
      weight_gap = 0;
    end else if (!weight_valid || weight_ready) begin
      if (weight_gap > 0) begin
        weight_valid <= 1'b0;
        weight_gap--;
      end else if (weight_todo.size() > 0) begin
        weight       <= weight_todo.pop_front();
        weight_valid <= 1'b1;
        weight_gap = {$random(weight_seed)} % (weight_gap_max + 1);
      end else begin
        weight_valid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      result_ready <= 1'b0;
      ready_burst = 0;
    end else if (ready_mode == READY_LOW) begin
      result_ready <= 1'b0;
    end else if (ready_mode == READY_HIGH) begin
      result_ready <= 1'b1;
    end else if (ready_burst == 0) begin
      result_ready <= ~result_ready;
      ready_burst = 1 + {$random(ready_seed)} % 6;
    end else begin
      ready_burst--;
    end
  end

  // results must pair the accepted blocks in acceptance order.
  always @(posedge clk) begin : scoreboard
    mx_block_t a_blk;
    mx_block_t w_blk;
    if (rst_n) begin
      if (result_valid && result_ready) begin
        assert (act_q.size() > 0 && weight_q.size() > 0)
          else report_failure("a result came out with no accepted block pair behind it");
        a_blk = act_q.pop_front();
        w_blk = weight_q.pop_front();
        assert (result.man == expected_sum(a_blk, w_blk))
          else report_value_error("mantissa sum", int'(expected_sum(a_blk, w_blk)),
                                  int'(result.man));
        assert (result.exp == expected_exp(a_blk, w_blk))
          else report_value_error("exponent sum", int'(expected_exp(a_blk, w_blk)),
                                  int'(result.exp));
        result_count++;
      end
      if (act_valid && act_ready) begin
        act_q.push_back(act);
      end
      if (weight_valid && weight_ready) begin
        weight_q.push_back(weight);
      end
    end
  end

  always @(negedge clk) begin
    if (uut.protocol_checks.fail_count != 0) begin
      report_failure("a bound protocol assertion failed");
    end
  end

  initial begin
    mx_result_t held;
    int         latency;

    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      if (i == RESET_CYCLES - 1) begin
        rst_n <= 1'b1;
      end
      @(negedge clk);
      assert (!result_valid) else report_value_error("result_valid", 0, int'(result_valid));
    end
    assert (act_ready && weight_ready)
      else report_failure("input ready is low right after reset");

    test_name = "latency";
    ready_mode = READY_HIGH;
    idle_cycles(2);
    queue_blocks(1, 1);
    wait_both_accepted();
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
      if (latency > WAIT_LIMIT) begin
        report_failure("timed out waiting for the first result");
      end
    end while (!result_valid);
    assert (latency == LATENCY) else report_value_error("result latency", LATENCY, latency);
    wait_drained();

    test_name = "backpressure";
    ready_mode = READY_LOW;
    idle_cycles(2);
    queue_blocks(8, 8);
    wait_result_valid();
    held = result;
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      @(negedge clk);
      assert (result_valid) else report_failure("result_valid dropped while it was blocked");
      assert (result.man == held.man)
        else report_value_error("held mantissa", int'(held.man), int'(result.man));
      assert (result.exp == held.exp)
        else report_value_error("held exponent", int'(held.exp), int'(result.exp));
    end
    assert (!act_ready && !weight_ready)
      else report_failure("input ready stayed high while the output was blocked");
    ready_mode = READY_RANDOM;
    wait_drained();

    test_name = "skew";
    act_gap_max    = 1;
    weight_gap_max = 3;
    queue_blocks(4, 0); // act runs four blocks ahead.
    idle_cycles(10);
    queue_blocks(4, 8);
    wait_drained();
    queue_blocks(0, 4); // now weight leads.
    idle_cycles(10);
    queue_blocks(8, 4);
    wait_drained();

    test_name = "random";
    act_gap_max    = 3;
    weight_gap_max = 2;
    queue_blocks(TOTAL_RESULTS - result_count, TOTAL_RESULTS - result_count);
    wait_drained();

    if (result_count == TOTAL_RESULTS) begin
      $display("TEST OK");
      $finish;
    end else begin
      report_value_error("result count", TOTAL_RESULTS, result_count);
    end
  end

endmodule

// ==== dv/mxint_dot_product_assertions.sv ====
`timescale 1ns/1ps

module mxint_dot_product_assertions (
  input logic                  clk,
  input logic                  rst_n,
  input mxint_pkg::mx_block_t  act,
  input logic                  act_valid,
  input logic                  act_ready,
  input mxint_pkg::mx_block_t  weight,
  input logic                  weight_valid,
  input logic                  weight_ready,
  input mxint_pkg::mx_result_t result,
  input logic                  result_valid,
  input logic                  result_ready
);

  int fail_count = 0;

  // the first cycle after reset has no result and both inputs open.
  property reset_clears_outputs;
    @(posedge clk) !rst_n |=> !result_valid && act_ready && weight_ready;
  endproperty

  property act_held;
    @(posedge clk) disable iff (!rst_n)
      act_valid && !act_ready |=> act_valid && $stable(act);
  endproperty

  property weight_held;
    @(posedge clk) disable iff (!rst_n)
      weight_valid && !weight_ready |=> weight_valid && $stable(weight);
  endproperty

  property result_held;
    @(posedge clk) disable iff (!rst_n)
      result_valid && !result_ready |=> result_valid && $stable(result);
  endproperty

  // a pair taken together comes out five cycles later when nothing stalls.
  property no_stall_latency;
    @(posedge clk) disable iff (!rst_n)
      (act_valid && act_ready && weight_valid && weight_ready) ##1 result_ready [*4]
        |=> result_valid;
  endproperty

  reset_outputs_a: assert property (reset_clears_outputs) else begin
    $error("outputs not cleared after reset");
    fail_count++;
  end

  act_held_a: assert property (act_held) else begin
    $error("act changed before its transfer");
    fail_count++;
  end

  weight_held_a: assert property (weight_held) else begin
    $error("weight changed before its transfer");
    fail_count++;
  end

  result_held_a: assert property (result_held) else begin
    $error("result changed before its transfer");
    fail_count++;
  end

  latency_a: assert property (no_stall_latency) else begin
    $error("result missing five cycles after acceptance");
    fail_count++;
  end

endmodule

bind mxint_dot_product mxint_dot_product_assertions protocol_checks (
  .clk          (clk),
  .rst_n        (rst_n),
  .act          (act),
  .act_valid    (act_valid),
  .act_ready    (act_ready),
  .weight       (weight),
  .weight_valid (weight_valid),
  .weight_ready (weight_ready),
  .result       (result),
  .result_valid (result_valid),
  .result_ready (result_ready)
);

// ==== hw/mxint_dot_product.sv ====
`timescale 1ns/1ps

module mxint_dot_product (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mxint_pkg::mx_block_t  act,
  input  logic                  act_valid,
  output logic                  act_ready,
  input  mxint_pkg::mx_block_t  weight,
  input  logic                  weight_valid,
  output logic                  weight_ready,
  output mxint_pkg::mx_result_t result,
  output logic                  result_valid,
  input  logic                  result_ready
);
  import mxint_pkg::*;

  man_vec_t act_man;
  logic     act_man_valid;
  logic     act_man_ready;
  exp_t     act_exp;
  logic     act_exp_valid;
  logic     act_exp_ready;

  man_vec_t weight_man;
  logic     weight_man_valid;
  logic     weight_man_ready;
  exp_t     weight_exp;
  logic     weight_exp_valid;
  logic     weight_exp_ready;

  acc_t     sum;
  logic     sum_valid;
  logic     sum_ready;

  mx_split_buffer act_split (
    .clk       (clk),
    .rst_n     (rst_n),
    .blk       (act),
    .blk_valid (act_valid),
    .blk_ready (act_ready),
    .man       (act_man),
    .man_valid (act_man_valid),
    .man_ready (act_man_ready),
    .exp       (act_exp),
    .exp_valid (act_exp_valid),
    .exp_ready (act_exp_ready)
  );

  mx_split_buffer weight_split (
    .clk       (clk),
    .rst_n     (rst_n),
    .blk       (weight),
    .blk_valid (weight_valid),
    .blk_ready (weight_ready),
    .man       (weight_man),
    .man_valid (weight_man_valid),
    .man_ready (weight_man_ready),
    .exp       (weight_exp),
    .exp_valid (weight_exp_valid),
    .exp_ready (weight_exp_ready)
  );

  fixed_dot_product fdp (
    .clk          (clk),
    .rst_n        (rst_n),
    .act_man      (act_man),
    .act_valid    (act_man_valid),
    .act_ready    (act_man_ready),
    .weight_man   (weight_man),
    .weight_valid (weight_man_valid),
    .weight_ready (weight_man_ready),
    .sum          (sum),
    .sum_valid    (sum_valid),
    .sum_ready    (sum_ready)
  );

  mx_result_join result_join (
    .sum              (sum),
    .sum_valid        (sum_valid),
    .sum_ready        (sum_ready),
    .act_exp          (act_exp),
    .act_exp_valid    (act_exp_valid),
    .act_exp_ready    (act_exp_ready),
    .weight_exp       (weight_exp),
    .weight_exp_valid (weight_exp_valid),
    .weight_exp_ready (weight_exp_ready),
    .result           (result),
    .result_valid     (result_valid),
    .result_ready     (result_ready)
  );

endmodule

// ==== hw/mx_result_join.sv ====
`timescale 1ns/1ps

module mx_result_join (
  input  logic                  sum_valid,
  input  mxint_pkg::acc_t       sum,
  output logic                  sum_ready,
  input  mxint_pkg::exp_t       act_exp,
  input  logic                  act_exp_valid,
  output logic                  act_exp_ready,
  input  mxint_pkg::exp_t       weight_exp,
  input  logic                  weight_exp_valid,
  output logic                  weight_exp_ready,
  output mxint_pkg::mx_result_t result,
  output logic                  result_valid,
  input  logic                  result_ready
);
  import mxint_pkg::*;

  out_exp_t exp_sum;

  // the three inputs leave together or not at all.
  assign result_valid     = sum_valid && act_exp_valid && weight_exp_valid;
  assign sum_ready        = result_ready && act_exp_valid && weight_exp_valid;
  assign act_exp_ready    = result_ready && sum_valid && weight_exp_valid;
  assign weight_exp_ready = result_ready && sum_valid && act_exp_valid;

  assign exp_sum = out_exp_t'(act_exp) + out_exp_t'(weight_exp); // both sign extended.

  always_comb begin
    result.man = sum;
    result.exp = exp_sum;
  end

endmodule

// ==== hw/fixed_dot_product.sv ====
`timescale 1ns/1ps
`include "mxint_macros.svh"

module fixed_dot_product (
  input  logic                clk,
  input  logic                rst_n,
  input  mxint_pkg::man_vec_t act_man,
  input  logic                act_valid,
  output logic                act_ready,
  input  mxint_pkg::man_vec_t weight_man,
  input  logic                weight_valid,
  output logic                weight_ready,
  output mxint_pkg::acc_t     sum,
  output logic                sum_valid,
  input  logic                sum_ready
);
  import mxint_pkg::*;

  localparam int N          = `MX_BLOCK_SIZE;
  localparam int TREE_DEPTH = $clog2(N);

  // number of live terms after the given number of tree levels.
  function automatic int level_width(input int level);
    int width;
    width = N;
    for (int k = 0; k < level; k++) begin
      width = (width + 1) / 2;
    end
    return width;
  endfunction

  acc_t                level_d [TREE_DEPTH+1][N];
  acc_t                level_q [TREE_DEPTH+1][N];
  logic [TREE_DEPTH:0] valid_q;
  logic                advance;
  logic                in_fire;

  // all stages share a single advance condition.
  assign advance = !valid_q[TREE_DEPTH] || sum_ready;

  // both vectors are consumed in the same cycle.
  assign act_ready    = advance && weight_valid;
  assign weight_ready = advance && act_valid;
  assign in_fire      = act_valid && weight_valid && advance;

  always_comb begin
    for (int lv = 0; lv <= TREE_DEPTH; lv++) begin
      for (int i = 0; i < N; i++) begin
        level_d[lv][i] = '0;
      end
    end

    for (int i = 0; i < N; i++) begin
      level_d[0][i] = acc_t'(act_man[i]) * acc_t'(weight_man[i]); // sign extended first.
    end

    for (int lv = 1; lv <= TREE_DEPTH; lv++) begin
      for (int i = 0; i < N; i++) begin
        if (i < level_width(lv)) begin
          if (2 * i + 1 < level_width(lv - 1)) begin
            level_d[lv][i] = level_q[lv-1][2*i] + level_q[lv-1][2*i+1];
          end else begin
            level_d[lv][i] = level_q[lv-1][2*i]; // odd term moves up unchanged.
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q <= {valid_q[TREE_DEPTH-1:0], in_fire};
    end
  end

  // stage zero holds the products and the later stages hold the tree levels.
  always_ff @(posedge clk) begin
    if (advance) begin
      level_q <= level_d;
    end
  end

  assign sum       = level_q[TREE_DEPTH][0];
  assign sum_valid = valid_q[TREE_DEPTH];

endmodule

// ==== hw/mx_split_buffer.sv ====
`timescale 1ns/1ps
`include "mxint_macros.svh"

module mx_split_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mxint_pkg::mx_block_t blk,
  input  logic                 blk_valid,
  output logic                 blk_ready,
  output mxint_pkg::man_vec_t  man,
  output logic                 man_valid,
  input  logic                 man_ready,
  output mxint_pkg::exp_t      exp,
  output logic                 exp_valid,
  input  logic                 exp_ready
);
  import mxint_pkg::*;

  localparam int DEPTH = `MX_EXP_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  man_vec_t         man_q;
  logic             man_valid_q;
  exp_t             fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             fifo_full;
  logic             man_free;
  logic             push;
  logic             pop;

  assign fifo_full = (count == CNT_W'(DEPTH));
  assign man_free  = !man_valid_q || man_ready; // register empties in this cycle.

  // a block is taken only when both halves have room.
  assign blk_ready = !fifo_full && man_free;
  assign push      = blk_valid && blk_ready;
  assign pop       = exp_valid && exp_ready;

  assign man       = man_q;
  assign man_valid = man_valid_q;
  assign exp       = fifo_mem[rd_ptr];
  assign exp_valid = (count != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      man_valid_q <= 1'b0;
    end else if (push) begin
      man_valid_q <= 1'b1;
    end else if (man_ready) begin
      man_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      man_q <= blk.man;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= blk.exp;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== hw/mxint_pkg.sv ====
`include "mxint_macros.svh"

package mxint_pkg;

  // one signed mantissa of a block.
  typedef logic signed [`MX_MAN_W-1:0] man_t;

  typedef logic signed [`MX_EXP_W-1:0] exp_t;

  // an unnormalized sum of products.
  typedef logic signed [`MX_ACC_W-1:0] acc_t;

  // one extra bit so the sum of two exponents cannot overflow.
  typedef logic signed [`MX_EXP_W:0] out_exp_t;

  typedef man_t [`MX_BLOCK_SIZE-1:0] man_vec_t;

  typedef struct packed {
    man_vec_t man;
    exp_t     exp;
  } mx_block_t;

  typedef struct packed {
    acc_t     man;
    out_exp_t exp;
  } mx_result_t;

endpackage

// ==== hw/mxint_macros.svh ====
`ifndef MXINT_MACROS_SVH
`define MXINT_MACROS_SVH

// elements that share one exponent in a block.
`define MX_BLOCK_SIZE 6

// activations and weights use the same mantissa width.
`define MX_MAN_W 8

`define MX_EXP_W 8

// full product width plus the growth of the adder tree.
`define MX_ACC_W (2 * `MX_MAN_W + $clog2(`MX_BLOCK_SIZE))

// one entry per stage that can hold a block in the mantissa path.
`define MX_EXP_FIFO_DEPTH ($clog2(`MX_BLOCK_SIZE) + 2)

`endif
